// File: rtl/ahbPkg.sv
// AHB-Lite bus definitions

package ahbPkg;

  ////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////

  // Address and data widths of the single-master bus
  localparam int addrWidth = 32;
  localparam int dataWidth = 32;

  // Every transfer is a full word, so the low address bits only select bytes
  localparam int wordOffsetBits = 2;

  typedef logic [addrWidth-1:0] addrT;
  typedef logic [dataWidth-1:0] dataT;

  ////////////////////////////////////////
  // Transfer types and responses
  ////////////////////////////////////////

  // HTRANS encodings as defined by the AHB-Lite protocol
  typedef enum logic [1:0] {
    htransIdle   = 2'b00,
    htransBusy   = 2'b01,
    htransNonseq = 2'b10,
    htransSeq    = 2'b11
  } htransT;

  // HRESP is a single bit on AHB-Lite
  localparam logic hrespOkay  = 1'b0;
  localparam logic hrespError = 1'b1;

endpackage

// File: rtl/memMapPkg.sv
// Memory map of the subsystem

package memMapPkg;

  ////////////////////////////////////////
  // Data-phase owners
  ////////////////////////////////////////

  // Index of the slave that owns the current data phase
  // The default slave also covers IDLE and BUSY transfers
  typedef enum logic [1:0] {
    slvMainRam    = 2'b00,
    slvScratchRam = 2'b01,
    slvDefault    = 2'b10
  } slaveIdxT;

  ////////////////////////////////////////
  // Regions
  ////////////////////////////////////////

  // Main RAM sits at the bottom of the address space
  localparam ahbPkg::addrT mainRamBase = 32'h0000_0000;
  localparam ahbPkg::addrT mainRamSize = 32'h0000_1000;

  // Scratch RAM is a small region at 256 MiB
  localparam ahbPkg::addrT scratchRamBase = 32'h1000_0000;
  localparam ahbPkg::addrT scratchRamSize = 32'h0000_0400;

  // Both bases are aligned to their sizes and both sizes are powers of two
  // The decoder relies on this to compare only the upper address bits

  ////////////////////////////////////////
  // RAM depths
  ////////////////////////////////////////

  // Depth in 32-bit words, derived from the region sizes
  localparam int mainRamWords    = int'(mainRamSize >> ahbPkg::wordOffsetBits);
  localparam int scratchRamWords = int'(scratchRamSize >> ahbPkg::wordOffsetBits);

endpackage

// File: rtl/ahbAddrDecode.sv
// AHB-Lite address decoder

`timescale 1ns/1ps

module ahbAddrDecode (
  input  ahbPkg::addrT         haddr,
  input  ahbPkg::htransT       htrans,
  output logic                 selMainRam,
  output logic                 selScratchRam,
  output logic                 selDefault,
  output memMapPkg::slaveIdxT  addrSlave
);

  logic hitMain;
  logic hitScratch;
  logic transActive;

  // True when addr falls inside an aligned power-of-two region
  function automatic logic inRegion(ahbPkg::addrT addr, ahbPkg::addrT base,
                                    ahbPkg::addrT size);
    return (addr & ~(size - ahbPkg::addrT'(1))) == base;
  endfunction

  ////////////////////////////////////////
  // Region compare
  ////////////////////////////////////////

  assign hitMain    = inRegion(haddr, memMapPkg::mainRamBase, memMapPkg::mainRamSize);
  assign hitScratch = inRegion(haddr, memMapPkg::scratchRamBase, memMapPkg::scratchRamSize);

  // Only NONSEQ and SEQ carry a real transfer
  assign transActive = (htrans == ahbPkg::htransNonseq) || (htrans == ahbPkg::htransSeq);

  // Selects follow the address alone, so exactly one is high in every cycle
  // Each slave qualifies its select with htrans itself
  always_comb begin
    selMainRam    = 1'b0;
    selScratchRam = 1'b0;
    selDefault    = 1'b0;
    if (hitMain) begin
      selMainRam = 1'b1;
    end else if (hitScratch) begin
      selScratchRam = 1'b1;
    end else begin
      selDefault = 1'b1;
    end
  end

  // Index for the response multiplexer
  // IDLE and BUSY are answered by the default slave with OKAY and no wait
  always_comb begin
    if (!transActive) begin
      addrSlave = memMapPkg::slvDefault;
    end else if (hitMain) begin
      addrSlave = memMapPkg::slvMainRam;
    end else if (hitScratch) begin
      addrSlave = memMapPkg::slvScratchRam;
    end else begin
      addrSlave = memMapPkg::slvDefault;
    end
  end

endmodule

// File: rtl/ahbSimpleRam.sv
// Zero-wait AHB-Lite word RAM

`timescale 1ns/1ps

module ahbSimpleRam #(
  parameter int depthWords = 1024
) (
  input  logic           clk,
  input  logic           rstN,
  input  logic           hsel,
  input  ahbPkg::addrT   haddr,
  input  ahbPkg::htransT htrans,
  input  logic           hwrite,
  input  logic           hready,
  input  ahbPkg::dataT   hwdata,
  output ahbPkg::dataT   readData,
  output logic           readyOut,
  output logic           resp
);

  // Width of the word index into the array
  localparam int idxBits = $clog2(depthWords);

  ahbPkg::dataT           mem [depthWords];
  logic [idxBits-1:0]     wordIdxQ;
  logic                   writeQ;
  logic                   activeQ;
  logic                   accept;

  ////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////

  // A transfer is taken when the bus is ready, we are selected and it is
  // NONSEQ or SEQ (SEQ is handled exactly like NONSEQ)
  assign accept = hready && hsel &&
                  ((htrans == ahbPkg::htransNonseq) || (htrans == ahbPkg::htransSeq));

  // The active flag clears on reset and whenever an accepted address phase
  // belongs to another slave or is IDLE or BUSY
  // The write flag only counts together with the active flag
  always_ff @(posedge clk) begin
    if (!rstN) begin
      activeQ <= 1'b0;
      writeQ  <= 1'b0;
    end else if (hready) begin
      activeQ <= accept;
      writeQ  <= hwrite;
    end
  end

  // Word index above the byte offset, truncated to the RAM depth
  always_ff @(posedge clk) begin
    if (accept) begin
      wordIdxQ <= haddr[ahbPkg::wordOffsetBits +: idxBits];
    end
  end

  ////////////////////////////////////////
  // Data phase
  ////////////////////////////////////////

  // The write lands at the edge that ends the data phase
  always_ff @(posedge clk) begin
    if (activeQ && writeQ && hready) begin
      mem[wordIdxQ] <= hwdata;
    end
  end

  // Read straight from the registered index, so a read right after a write
  // to the same word already sees the new value
  assign readData = mem[wordIdxQ];

  // Never stalls and never fails
  assign readyOut = 1'b1;
  assign resp     = ahbPkg::hrespOkay;

endmodule

// File: rtl/ahbDefaultSlave.sv
// AHB-Lite default slave

`timescale 1ns/1ps

module ahbDefaultSlave (
  input  logic           clk,
  input  logic           rstN,
  input  logic           hsel,
  input  ahbPkg::htransT htrans,
  input  logic           hready,
  output ahbPkg::dataT   readData,
  output logic           readyOut,
  output logic           resp
);

  // Two-cycle ERROR sequence required by AHB-Lite
  typedef enum logic [1:0] {
    idle,
    errFirst,
    errSecond
  } stateT;

  stateT state;
  stateT stateNext;
  logic  accept;

  // Active transfer to an unmapped address accepted this edge
  assign accept = hready && hsel &&
                  ((htrans == ahbPkg::htransNonseq) || (htrans == ahbPkg::htransSeq));

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_comb begin
    case (state)
      // hready is low here, so nothing new can arrive
      errFirst: stateNext = errSecond;
      // From idle or the last ERROR cycle a new unmapped transfer restarts
      // the sequence right away
      default:  stateNext = accept ? errFirst : idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= idle;
    end else begin
      state <= stateNext;
    end
  end

  // First ERROR cycle stalls the bus, the second one completes it
  assign readyOut = (state != errFirst);
  assign resp     = (state == idle) ? ahbPkg::hrespOkay : ahbPkg::hrespError;
  assign readData = '0;

endmodule

// File: rtl/ahbResponseMux.sv
// AHB-Lite response multiplexer

`timescale 1ns/1ps

module ahbResponseMux (
  input  logic                clk,
  input  logic                rstN,
  input  logic                hready,
  input  memMapPkg::slaveIdxT addrSlave,
  input  ahbPkg::dataT        readDataMain,
  input  logic                readyOutMain,
  input  logic                respMain,
  input  ahbPkg::dataT        readDataScratch,
  input  logic                readyOutScratch,
  input  logic                respScratch,
  input  ahbPkg::dataT        readDataDefault,
  input  logic                readyOutDefault,
  input  logic                respDefault,
  output ahbPkg::dataT        hrdata,
  output logic                hreadyOut,
  output logic                hrespOut
);

  // Slave that owns the current data phase
  memMapPkg::slaveIdxT dataSlaveQ;

  ////////////////////////////////////////
  // Data-phase owner
  ////////////////////////////////////////

  // Moves on only when an address phase is accepted
  // Out of reset the default slave owns the bus and answers OKAY
  always_ff @(posedge clk) begin
    if (!rstN) begin
      dataSlaveQ <= memMapPkg::slvDefault;
    end else if (hready) begin
      dataSlaveQ <= addrSlave;
    end
  end

  ////////////////////////////////////////
  // Result steering
  ////////////////////////////////////////

  always_comb begin
    case (dataSlaveQ)
      memMapPkg::slvMainRam: begin
        hrdata    = readDataMain;
        hreadyOut = readyOutMain;
        hrespOut  = respMain;
      end
      memMapPkg::slvScratchRam: begin
        hrdata    = readDataScratch;
        hreadyOut = readyOutScratch;
        hrespOut  = respScratch;
      end
      // slvDefault and the unused encoding
      default: begin
        hrdata    = readDataDefault;
        hreadyOut = readyOutDefault;
        hrespOut  = respDefault;
      end
    endcase
  end

endmodule

// File: rtl/ahbMemSubsystem.sv
// AHB-Lite memory subsystem top

`timescale 1ns/1ps

module ahbMemSubsystem (
  input  logic           clk,
  input  logic           rstN,
  input  ahbPkg::addrT   haddr,
  input  ahbPkg::htransT htrans,
  input  logic           hwrite,
  input  ahbPkg::dataT   hwdata,
  output ahbPkg::dataT   hrdata,
  output logic           hready,
  output logic           hresp
);

  // Decoder outputs
  logic                selMainRam;
  logic                selScratchRam;
  logic                selDefault;
  memMapPkg::slaveIdxT addrSlave;

  // Per-slave result buses
  ahbPkg::dataT readDataMain;
  logic         readyOutMain;
  logic         respMain;
  ahbPkg::dataT readDataScratch;
  logic         readyOutScratch;
  logic         respScratch;
  ahbPkg::dataT readDataDefault;
  logic         readyOutDefault;
  logic         respDefault;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  ahbAddrDecode decode_i (
    .haddr         (haddr),
    .htrans        (htrans),
    .selMainRam    (selMainRam),
    .selScratchRam (selScratchRam),
    .selDefault    (selDefault),
    .addrSlave     (addrSlave)
  );

  ////////////////////////////////////////
  // Slaves
  ////////////////////////////////////////

  // All slaves see the multiplexed HREADY as the bus ready
  ahbSimpleRam #(
    .depthWords (memMapPkg::mainRamWords)
  ) mainRam_i (
    .clk      (clk),
    .rstN     (rstN),
    .hsel     (selMainRam),
    .haddr    (haddr),
    .htrans   (htrans),
    .hwrite   (hwrite),
    .hready   (hready),
    .hwdata   (hwdata),
    .readData (readDataMain),
    .readyOut (readyOutMain),
    .resp     (respMain)
  );

  ahbSimpleRam #(
    .depthWords (memMapPkg::scratchRamWords)
  ) scratchRam_i (
    .clk      (clk),
    .rstN     (rstN),
    .hsel     (selScratchRam),
    .haddr    (haddr),
    .htrans   (htrans),
    .hwrite   (hwrite),
    .hready   (hready),
    .hwdata   (hwdata),
    .readData (readDataScratch),
    .readyOut (readyOutScratch),
    .resp     (respScratch)
  );

  // Catches every unmapped address
  ahbDefaultSlave defaultSlave_i (
    .clk      (clk),
    .rstN     (rstN),
    .hsel     (selDefault),
    .htrans   (htrans),
    .hready   (hready),
    .readData (readDataDefault),
    .readyOut (readyOutDefault),
    .resp     (respDefault)
  );

  ////////////////////////////////////////
  // Result
  ////////////////////////////////////////

  ahbResponseMux responseMux_i (
    .clk             (clk),
    .rstN            (rstN),
    .hready          (hready),
    .addrSlave       (addrSlave),
    .readDataMain    (readDataMain),
    .readyOutMain    (readyOutMain),
    .respMain        (respMain),
    .readDataScratch (readDataScratch),
    .readyOutScratch (readyOutScratch),
    .respScratch     (respScratch),
    .readDataDefault (readDataDefault),
    .readyOutDefault (readyOutDefault),
    .respDefault     (respDefault),
    .hrdata          (hrdata),
    .hreadyOut       (hready),
    .hrespOut        (hresp)
  );

endmodule

// File: tests/ahbMemSubsystem_assertions.sv
// Memory subsystem protocol checks

`timescale 1ns/1ps

module ahbMemSubsystemAssertions (
  input logic                clk,
  input logic                rstN,
  input logic                hready,
  input logic                hresp,
  input memMapPkg::slaveIdxT addrSlave
);

  // Data-phase owner tracked independently of the multiplexer
  memMapPkg::slaveIdxT ownerQ;
  logic                ramOwned;

  // Running total of failed properties
  int                  failCount = 0;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      ownerQ <= memMapPkg::slvDefault;
    end else if (hready) begin
      ownerQ <= addrSlave;
    end
  end

  assign ramOwned = (ownerQ == memMapPkg::slvMainRam) ||
                    (ownerQ == memMapPkg::slvScratchRam);

  ////////////////////////////////////////
  // Properties
  ////////////////////////////////////////

  // First cycle out of reset the bus is free
  readyAfterReset: assert property (@(posedge clk) $rose(rstN) |-> hready)
    else begin
      failCount++;
      $error("hready low in the first cycle after reset");
    end

  // The stalled ERROR cycle is always completed by a second ERROR cycle
  errorTwoCycles: assert property (@(posedge clk) disable iff (!rstN)
    (hresp == ahbPkg::hrespError && !hready) |=> (hresp == ahbPkg::hrespError && hready))
    else begin
      failCount++;
      $error("ERROR response not completed in its second cycle");
    end

  // RAMs never fail a transfer
  ramAlwaysOkay: assert property (@(posedge clk) disable iff (!rstN)
    ramOwned |-> (hresp == ahbPkg::hrespOkay))
    else begin
      failCount++;
      $error("hresp not OKAY in a RAM data phase");
    end

endmodule

bind ahbMemSubsystem ahbMemSubsystemAssertions assertions_i (
  .clk       (clk),
  .rstN      (rstN),
  .hready    (hready),
  .hresp     (hresp),
  .addrSlave (addrSlave)
);

// File: tests/ahbMemSubsystemTb.sv
// Memory subsystem testbench

`timescale 1ns/1ps

module ahbMemSubsystemTb;

  // Longest handshake wait in cycles
  localparam int maxWait = 20;

  // A transfer in its data phase together with the result the model expects
  typedef struct {
    ahbPkg::dataT data;
    logic         resp;
    bit           checkData;
    int           cycles;
  } phaseT;

  logic           clk;
  logic           rstN;
  ahbPkg::addrT   haddr;
  ahbPkg::htransT htrans;
  logic           hwrite;
  ahbPkg::dataT   hwdata;
  ahbPkg::dataT   hrdata;
  logic           hready;
  logic           hresp;

  // Mirror of both RAMs, keyed by word-aligned address
  ahbPkg::dataT refMem [ahbPkg::addrT];
  phaseT        inFlight [$];
  ahbPkg::dataT nextWdata;
  int           seed;
  int           dataCycles;
  int           checkCount;
  int           errCount;
  int           assertFails;

  ahbMemSubsystem dut_i (
    .clk    (clk),
    .rstN   (rstN),
    .haddr  (haddr),
    .htrans (htrans),
    .hwrite (hwrite),
    .hwdata (hwdata),
    .hrdata (hrdata),
    .hready (hready),
    .hresp  (hresp)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Address lies in one of the two RAM regions
  function automatic logic isMapped(ahbPkg::addrT addr);
    logic inMain;
    logic inScratch;
    inMain    = (addr >= memMapPkg::mainRamBase) &&
                (addr < memMapPkg::mainRamBase + memMapPkg::mainRamSize);
    inScratch = (addr >= memMapPkg::scratchRamBase) &&
                (addr < memMapPkg::scratchRamBase + memMapPkg::scratchRamSize);
    return inMain || inScratch;
  endfunction

  function automatic ahbPkg::addrT wordKey(ahbPkg::addrT addr);
    return addr & 32'hFFFF_FFFC;
  endfunction

  function automatic ahbPkg::dataT modelRead(ahbPkg::addrT addr);
    return refMem[wordKey(addr)];
  endfunction

  // IDLE and BUSY always get OKAY, active transfers fail outside the map
  function automatic logic expectedResp(ahbPkg::addrT addr, ahbPkg::htransT trans);
    if (trans == ahbPkg::htransIdle || trans == ahbPkg::htransBusy) begin
      return ahbPkg::hrespOkay;
    end
    return isMapped(addr) ? ahbPkg::hrespOkay : ahbPkg::hrespError;
  endfunction

  ////////////////////////////////////////
  // Checks and reporting
  ////////////////////////////////////////

  task automatic compareValue(string name, logic [31:0] actual, logic [31:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errCount++;
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic reportTimeout(string what);
    errCount++;
    $display("Timeout: %s after %0d cycles", what, maxWait);
  endtask

  // Outputs are steady between the falling edge and the edge that ends
  // the data phase, so every completed phase is judged there
  always @(negedge clk) begin : checkResults
    phaseT retired;
    if (rstN && inFlight.size() > 0) begin
      dataCycles++;
      if (hready) begin
        retired = inFlight.pop_front();
        compareValue("hresp", 32'(hresp), 32'(retired.resp));
        if (retired.checkData) begin
          compareValue("hrdata", hrdata, retired.data);
        end
        compareValue("dataCycles", 32'(dataCycles), 32'(retired.cycles));
        dataCycles = 0;
      end
    end
  end

  ////////////////////////////////////////
  // Master driver
  ////////////////////////////////////////

  // Presents one address phase together with the write data of the previous
  // transfer and returns 1 ns after the edge that accepts it
  task automatic busTransfer(ahbPkg::addrT addr, ahbPkg::htransT trans, logic write,
                             ahbPkg::dataT wdata);
    int    waited;
    logic  active;
    phaseT ph;
    active = (trans == ahbPkg::htransNonseq) || (trans == ahbPkg::htransSeq);
    haddr  = addr;
    htrans = trans;
    hwrite = write;
    hwdata = nextWdata;
    waited = 0;
    @(negedge clk);
    while (!hready && waited < maxWait) begin
      waited++;
      @(negedge clk);
    end
    if (!hready) begin
      reportTimeout("address phase not accepted");
    end
    @(posedge clk);
    #1;
    ph.resp      = expectedResp(addr, trans);
    ph.cycles    = (ph.resp == ahbPkg::hrespError) ? 2 : 1;
    ph.checkData = active && !write && isMapped(addr) && refMem.exists(wordKey(addr));
    ph.data      = ph.checkData ? modelRead(addr) : '0;
    if (active && write && isMapped(addr)) begin
      refMem[wordKey(addr)] = wdata;
    end
    inFlight.push_back(ph);
    nextWdata = wdata;
  endtask

  // Waits until the checker has retired every outstanding data phase
  task automatic drainBus();
    int waited;
    waited = 0;
    while (inFlight.size() > 0 && waited < maxWait) begin
      waited++;
      @(posedge clk);
    end
    if (inFlight.size() > 0) begin
      reportTimeout("data phases still outstanding");
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin : stimulus
    ahbPkg::addrT addrList [24];
    ahbPkg::addrT mainTop;
    ahbPkg::addrT scratchTop;
    seed        = 31;
    clk         = 1'b0;
    rstN        = 1'b0;
    haddr       = '0;
    htrans      = ahbPkg::htransIdle;
    hwrite      = 1'b0;
    hwdata      = '0;
    nextWdata   = '0;
    dataCycles  = 0;
    checkCount  = 0;
    errCount    = 0;
    assertFails = 0;
    repeat (16) @(posedge clk);
    #1;
    rstN = 1'b1;

    // Idle bus right after reset
    @(negedge clk);
    compareValue("hready", 32'(hready), 32'd1);
    compareValue("hresp", 32'(hresp), 32'(ahbPkg::hrespOkay));
    @(posedge clk);
    #1;

    // Random words across main RAM, read back in reverse with SEQ mixed in
    for (int i = 0; i < 24; i++) begin
      addrList[i] = memMapPkg::mainRamBase +
                    ({$random(seed)} % memMapPkg::mainRamWords) * 4;
      busTransfer(addrList[i], ahbPkg::htransNonseq, 1'b1, $random(seed));
    end
    for (int i = 23; i >= 0; i--) begin
      busTransfer(addrList[i], (i % 2 == 1) ? ahbPkg::htransSeq : ahbPkg::htransNonseq,
                  1'b0, '0);
    end

    // Same offsets in both regions hold different data
    for (int i = 0; i < 8; i++) begin
      busTransfer(memMapPkg::mainRamBase + 32'(i * 4), ahbPkg::htransNonseq, 1'b1,
                  32'hA500_0000 + 32'(i));
      busTransfer(memMapPkg::scratchRamBase + 32'(i * 4), ahbPkg::htransNonseq, 1'b1,
                  32'h5A00_0000 + 32'(i));
    end
    for (int i = 0; i < 8; i++) begin
      busTransfer(memMapPkg::mainRamBase + 32'(i * 4), ahbPkg::htransNonseq, 1'b0, '0);
      busTransfer(memMapPkg::scratchRamBase + 32'(i * 4), ahbPkg::htransNonseq, 1'b0, '0);
    end

    // Read issued in the data phase of a write to the same word
    scratchTop = memMapPkg::scratchRamBase + memMapPkg::scratchRamSize - 32'd4;
    mainTop    = memMapPkg::mainRamBase + memMapPkg::mainRamSize - 32'd4;
    busTransfer(scratchTop, ahbPkg::htransNonseq, 1'b1, 32'hC0DE_0001);
    busTransfer(scratchTop, ahbPkg::htransNonseq, 1'b0, '0);
    busTransfer(mainTop, ahbPkg::htransNonseq, 1'b1, 32'hC0DE_0002);
    busTransfer(mainTop, ahbPkg::htransNonseq, 1'b0, '0);

    // Unmapped transfers, two of them just past each RAM where a truncated
    // index would alias word 0
    busTransfer(32'h2000_0000, ahbPkg::htransNonseq, 1'b1, 32'hDEAD_0001);
    busTransfer(memMapPkg::mainRamSize, ahbPkg::htransNonseq, 1'b1, 32'hDEAD_0002);
    busTransfer(memMapPkg::scratchRamBase + memMapPkg::scratchRamSize,
                ahbPkg::htransSeq, 1'b1, 32'hDEAD_0003);
    busTransfer(32'hFFFF_FFFC, ahbPkg::htransNonseq, 1'b0, '0);
    busTransfer(memMapPkg::mainRamBase, ahbPkg::htransNonseq, 1'b0, '0);
    busTransfer(memMapPkg::scratchRamBase, ahbPkg::htransNonseq, 1'b0, '0);

    // IDLE and BUSY with write set must leave the RAMs alone
    busTransfer(memMapPkg::mainRamBase + 32'd4, ahbPkg::htransIdle, 1'b1, 32'h0BAD_0001);
    busTransfer(memMapPkg::scratchRamBase + 32'd4, ahbPkg::htransBusy, 1'b1, 32'h0BAD_0002);
    busTransfer(memMapPkg::mainRamBase + 32'd4, ahbPkg::htransNonseq, 1'b0, '0);
    busTransfer(memMapPkg::scratchRamBase + 32'd4, ahbPkg::htransNonseq, 1'b0, '0);

    busTransfer('0, ahbPkg::htransIdle, 1'b0, '0);
    drainBus();

    assertFails = dut_i.assertions_i.failCount;
    $display("Checks %0d, errors %0d, assertion failures %0d",
             checkCount, errCount, assertFails);
    if (errCount == 0 && assertFails == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: build.f
rtl/ahbPkg.sv
rtl/memMapPkg.sv
rtl/ahbAddrDecode.sv
rtl/ahbSimpleRam.sv
rtl/ahbDefaultSlave.sv
rtl/ahbResponseMux.sv
rtl/ahbMemSubsystem.sv
tests/ahbMemSubsystem_assertions.sv
tests/ahbMemSubsystemTb.sv

// File: Makefile
# Verilator flow for the AHB-Lite memory subsystem

VERILATOR ?= verilator
TOP       ?= ahbMemSubsystemTb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= >>> PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The run passes only when the testbench printed its pass line
sim: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
